// ==== hdl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Operations understood by the core
	typedef enum logic [5:0] {
		op_nop,
		op_lda,
		op_ldx,
		op_ldy,
		op_sta,
		op_stx,
		op_sty,
		op_adc,
		op_sbc,
		op_and,
		op_ora,
		op_eor,
		op_asl,
		op_lsr,
		op_rol,
		op_ror,
		op_inx,
		op_iny,
		op_dex,
		op_dey,
		op_tax,
		op_tay,
		op_txa,
		op_tya,
		op_txs,
		op_tsx,
		op_sec,
		op_sed,
		op_sei,
		op_clc,
		op_cld,
		op_cli,
		op_clv,
		op_jmp,
		op_jsr
	} opcode_t;

	typedef enum logic [1:0] {
		imp,
		imm,
		abs
	} addr_mode_t;

	// Status register bit positions
	localparam int unsigned STATUS_C = 0;
	localparam int unsigned STATUS_Z = 1;
	localparam int unsigned STATUS_I = 2;
	localparam int unsigned STATUS_D = 3;
	localparam int unsigned STATUS_R = 5;
	localparam int unsigned STATUS_V = 6;
	localparam int unsigned STATUS_N = 7;

endpackage

// ==== hdl/cpu_dp_pkg.sv ====
package cpu_dp_pkg;

	typedef enum logic [3:0] {
		txa,
		txb,
		adc,
		sbc,
		add,
		sub,
		and_op,
		ora,
		eor,
		asl,
		lsr,
		rol,
		ror
	} alu_func_t;

	// ALU input A sources
	typedef enum logic [2:0] {
		a_bus,
		a_acc,
		a_x,
		a_y,
		a_sp
	} a_sel_t;

	typedef enum logic {
		b_bus,
		b_one
	} b_sel_t;

	// Where the ALU result goes
	typedef enum logic [2:0] {
		dst_none,
		dst_bus,
		dst_acc,
		dst_x,
		dst_y,
		dst_sp,
		dst_dll,
		dst_dlh
	} dst_t;

endpackage

// ==== hdl/opcode_decoder.sv ====
module opcode_decoder (
	input  logic [7:0]              ir_i,
	output cpu_isa_pkg::opcode_t    op_o,
	output cpu_isa_pkg::addr_mode_t mode_o
);
	import cpu_isa_pkg::*;

	// Operation from the standard 6502 encodings
	always_comb begin
		case (ir_i)
		8'ha9, 8'had: op_o = op_lda;
		8'ha2, 8'hae: op_o = op_ldx;
		8'ha0, 8'hac: op_o = op_ldy;
		8'h8d:        op_o = op_sta;
		8'h8e:        op_o = op_stx;
		8'h8c:        op_o = op_sty;
		8'h69, 8'h6d: op_o = op_adc;
		8'he9, 8'hed: op_o = op_sbc;
		8'h29, 8'h2d: op_o = op_and;
		8'h09, 8'h0d: op_o = op_ora;
		8'h49, 8'h4d: op_o = op_eor;
		8'h0a:        op_o = op_asl;
		8'h4a:        op_o = op_lsr;
		8'h2a:        op_o = op_rol;
		8'h6a:        op_o = op_ror;
		8'he8:        op_o = op_inx;
		8'hc8:        op_o = op_iny;
		8'hca:        op_o = op_dex;
		8'h88:        op_o = op_dey;
		8'haa:        op_o = op_tax;
		8'ha8:        op_o = op_tay;
		8'h8a:        op_o = op_txa;
		8'h98:        op_o = op_tya;
		8'h9a:        op_o = op_txs;
		8'hba:        op_o = op_tsx;
		8'h38:        op_o = op_sec;
		8'hf8:        op_o = op_sed;
		8'h78:        op_o = op_sei;
		8'h18:        op_o = op_clc;
		8'hd8:        op_o = op_cld;
		8'h58:        op_o = op_cli;
		8'hb8:        op_o = op_clv;
		8'h4c:        op_o = op_jmp;
		8'h20:        op_o = op_jsr;
		default:      op_o = op_nop;
		endcase
	end

	// Unknown bytes run as implied
	always_comb begin
		case (ir_i)
		8'ha9, 8'ha2, 8'ha0, 8'h69, 8'he9, 8'h29, 8'h09, 8'h49:
			mode_o = imm;
		8'had, 8'hae, 8'hac, 8'h8d, 8'h8e, 8'h8c,
		8'h6d, 8'hed, 8'h2d, 8'h0d, 8'h4d, 8'h4c, 8'h20:
			mode_o = abs;
		default:
			mode_o = imp;
		endcase
	end

endmodule

// ==== hdl/alu.sv ====
module alu (
	input  cpu_dp_pkg::alu_func_t func_i,
	input  logic [7:0]            a_i,
	input  logic [7:0]            b_i,
	input  logic                  carry_i,
	output logic [7:0]            result_o,
	output logic                  carry_o,
	output logic                  overflow_o
);
	import cpu_dp_pkg::*;

	logic [7:0] b_eff;
	logic       cin;
	logic [8:0] sum;

	// Subtraction adds the inverted operand
	always_comb begin
		b_eff = b_i;
		cin = 1'b0;
		case (func_i)
		adc: cin = carry_i;
		sbc: begin
			b_eff = ~b_i;
			cin = carry_i;
		end
		sub: begin
			b_eff = ~b_i;
			cin = 1'b1;
		end
		default: ;
		endcase
	end

	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {8'h00, cin};

	always_comb begin
		result_o = b_i;
		carry_o = carry_i;
		overflow_o = 1'b0;
		case (func_i)
		txa: result_o = a_i;
		adc, sbc, add, sub: begin
			result_o = sum[7:0];
			carry_o = sum[8];
			// Same operand signs, different result sign
			overflow_o = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);
		end
		and_op: result_o = a_i & b_i;
		ora: result_o = a_i | b_i;
		eor: result_o = a_i ^ b_i;
		asl: begin
			result_o = {a_i[6:0], 1'b0};
			carry_o = a_i[7];
		end
		lsr: begin
			result_o = {1'b0, a_i[7:1]};
			carry_o = a_i[0];
		end
		rol: begin
			result_o = {a_i[6:0], carry_i};
			carry_o = a_i[7];
		end
		ror: begin
			result_o = {carry_i, a_i[7:1]};
			carry_o = a_i[0];
		end
		default: ;
		endcase
	end

endmodule

// ==== hdl/sequencer.sv ====
module sequencer (
	input  logic                    sys_i,
	input  logic                    arst_n_i,
	input  cpu_isa_pkg::opcode_t    op_i,
	input  cpu_isa_pkg::addr_mode_t mode_i,
	output logic                    bus_we_o,
	output logic                    pc_addr_oe_o,
	output logic                    dl_addr_oe_o,
	output logic                    pc_inc_o,
	output logic                    pc_load_o,
	output logic                    ins_we_o,
	output cpu_dp_pkg::alu_func_t   alu_func_o,
	output cpu_dp_pkg::a_sel_t      a_sel_o,
	output cpu_dp_pkg::b_sel_t      b_sel_o,
	output cpu_dp_pkg::dst_t        dst_o,
	output logic [7:0]              p_mask_o,
	output logic [7:0]              p_set_o,
	output logic [7:0]              p_clr_o
);
	import cpu_isa_pkg::*;
	import cpu_dp_pkg::*;

	localparam logic [7:0] NZ_MASK = (8'b1 << STATUS_N) | (8'b1 << STATUS_Z);
	localparam logic [7:0] NZC_MASK = NZ_MASK | (8'b1 << STATUS_C);
	localparam logic [7:0] NZCV_MASK = NZC_MASK | (8'b1 << STATUS_V);

	typedef enum logic [2:0] {
		fetch,
		decode,
		jump_l,
		jump_h,
		read_h,
		absolute
	} state_t;

	state_t state;
	state_t state_next;
	logic   execute;

	// Reset starts with the vector read
	always_ff @(posedge sys_i, negedge arst_n_i) begin
		if (!arst_n_i)
			state <= jump_l;
		else
			state <= state_next;
	end

	always_comb begin
		bus_we_o = 1'b0;
		pc_addr_oe_o = 1'b0;
		dl_addr_oe_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		ins_we_o = 1'b0;
		alu_func_o = txb;
		a_sel_o = a_bus;
		b_sel_o = b_bus;
		dst_o = dst_none;
		p_mask_o = 8'h00;
		p_set_o = 8'h00;
		p_clr_o = 8'h00;
		state_next = state;
		execute = 1'b0;

		case (state)
		fetch: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			ins_we_o = 1'b1;
			state_next = decode;
		end
		decode: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = (mode_i != imp);
			if (mode_i == abs) begin
				dst_o = dst_dll;
				state_next = read_h;
			end else begin
				execute = 1'b1;
				state_next = fetch;
			end
		end
		read_h: begin
			pc_addr_oe_o = 1'b1;
			dst_o = dst_dlh;
			// JSR only goes as far as the jump
			if (op_i == op_jmp || op_i == op_jsr) begin
				pc_load_o = 1'b1;
				state_next = fetch;
			end else begin
				pc_inc_o = 1'b1;
				state_next = absolute;
			end
		end
		absolute: begin
			dl_addr_oe_o = 1'b1;
			execute = 1'b1;
			state_next = fetch;
		end
		jump_l: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			dst_o = dst_dll;
			state_next = jump_h;
		end
		jump_h: begin
			pc_addr_oe_o = 1'b1;
			pc_load_o = 1'b1;
			dst_o = dst_dlh;
			state_next = fetch;
		end
		default: state_next = jump_l;
		endcase

		if (execute) begin
			case (op_i)
			op_adc, op_sbc, op_and, op_ora, op_eor: begin
				a_sel_o = a_acc;
				dst_o = dst_acc;
				p_mask_o = NZ_MASK;
				case (op_i)
				op_adc: begin
					alu_func_o = adc;
					p_mask_o = NZCV_MASK;
				end
				op_sbc: begin
					alu_func_o = sbc;
					p_mask_o = NZCV_MASK;
				end
				op_and: alu_func_o = and_op;
				op_ora: alu_func_o = ora;
				default: alu_func_o = eor;
				endcase
			end
			op_asl, op_lsr, op_rol, op_ror: begin
				a_sel_o = a_acc;
				dst_o = dst_acc;
				p_mask_o = NZC_MASK;
				case (op_i)
				op_asl: alu_func_o = asl;
				op_lsr: alu_func_o = lsr;
				op_rol: alu_func_o = rol;
				default: alu_func_o = ror;
				endcase
			end
			op_inx, op_iny, op_dex, op_dey: begin
				b_sel_o = b_one;
				p_mask_o = NZ_MASK;
				alu_func_o = (op_i == op_inx || op_i == op_iny) ? add : sub;
				a_sel_o = (op_i == op_inx || op_i == op_dex) ? a_x : a_y;
				dst_o = (op_i == op_inx || op_i == op_dex) ? dst_x : dst_y;
			end
			// Loads take the bus byte as is
			op_lda: begin
				dst_o = dst_acc;
				p_mask_o = NZ_MASK;
			end
			op_ldx: begin
				dst_o = dst_x;
				p_mask_o = NZ_MASK;
			end
			op_ldy: begin
				dst_o = dst_y;
				p_mask_o = NZ_MASK;
			end
			op_sta, op_stx, op_sty: begin
				alu_func_o = txa;
				dst_o = dst_bus;
				bus_we_o = 1'b1;
				if (op_i == op_sta)
					a_sel_o = a_acc;
				else if (op_i == op_stx)
					a_sel_o = a_x;
				else
					a_sel_o = a_y;
			end
			op_tax, op_tay, op_txa, op_tya, op_tsx: begin
				alu_func_o = txa;
				p_mask_o = NZ_MASK;
				case (op_i)
				op_tax: begin
					a_sel_o = a_acc;
					dst_o = dst_x;
				end
				op_tay: begin
					a_sel_o = a_acc;
					dst_o = dst_y;
				end
				op_txa: begin
					a_sel_o = a_x;
					dst_o = dst_acc;
				end
				op_tya: begin
					a_sel_o = a_y;
					dst_o = dst_acc;
				end
				default: begin
					a_sel_o = a_sp;
					dst_o = dst_x;
				end
				endcase
			end
			// Flags untouched by TXS
			op_txs: begin
				alu_func_o = txa;
				a_sel_o = a_x;
				dst_o = dst_sp;
			end
			op_sec: p_set_o[STATUS_C] = 1'b1;
			op_sed: p_set_o[STATUS_D] = 1'b1;
			op_sei: p_set_o[STATUS_I] = 1'b1;
			op_clc: p_clr_o[STATUS_C] = 1'b1;
			op_cld: p_clr_o[STATUS_D] = 1'b1;
			op_cli: p_clr_o[STATUS_I] = 1'b1;
			op_clv: p_clr_o[STATUS_V] = 1'b1;
			default: ;
			endcase
		end
	end

endmodule

// ==== hdl/datapath.sv ====
module datapath #(
	parameter logic [15:0] RESET_VECTOR = 16'hfffc
) (
	input  logic                  sys_i,
	input  logic                  arst_n_i,
	input  logic                  bus_we_i,
	input  logic                  pc_addr_oe_i,
	input  logic                  dl_addr_oe_i,
	input  logic                  pc_inc_i,
	input  logic                  pc_load_i,
	input  logic                  ins_we_i,
	input  cpu_dp_pkg::alu_func_t alu_func_i,
	input  cpu_dp_pkg::a_sel_t    a_sel_i,
	input  cpu_dp_pkg::b_sel_t    b_sel_i,
	input  cpu_dp_pkg::dst_t      dst_i,
	input  logic [7:0]            p_mask_i,
	input  logic [7:0]            p_set_i,
	input  logic [7:0]            p_clr_i,
	input  logic [7:0]            data_i,
	output logic [15:0]           addr_o,
	output logic [7:0]            data_o,
	output logic                  we_o,
	output logic [7:0]            ir_o
);
	import cpu_isa_pkg::*;
	import cpu_dp_pkg::*;

	logic [7:0]  acc;
	logic [7:0]  x;
	logic [7:0]  y;
	logic [7:0]  sp;
	logic [7:0]  ir;
	logic [7:0]  p;
	logic [7:0]  dll;
	logic [7:0]  dlh;
	logic [15:0] pc;

	logic [7:0] alu_a;
	logic [7:0] alu_b;
	logic [7:0] alu_res;
	logic       alu_carry;
	logic       alu_ovf;
	logic [7:0] flag_val;
	logic [7:0] p_next;

	always_comb begin
		case (a_sel_i)
		a_acc:   alu_a = acc;
		a_x:     alu_a = x;
		a_y:     alu_a = y;
		a_sp:    alu_a = sp;
		default: alu_a = data_i;
		endcase
	end

	assign alu_b = (b_sel_i == b_one) ? 8'h01 : data_i;

	alu alu_i (
		.func_i     (alu_func_i),
		.a_i        (alu_a),
		.b_i        (alu_b),
		.carry_i    (p[STATUS_C]),
		.result_o   (alu_res),
		.carry_o    (alu_carry),
		.overflow_o (alu_ovf)
	);

	// Masked flags follow the ALU, then forced set and clear
	always_comb begin
		flag_val = 8'h00;
		flag_val[STATUS_N] = alu_res[7];
		flag_val[STATUS_Z] = (alu_res == 8'h00);
		flag_val[STATUS_C] = alu_carry;
		flag_val[STATUS_V] = alu_ovf;
		p_next = (p & ~p_mask_i) | (flag_val & p_mask_i);
		p_next = (p_next | p_set_i) & ~p_clr_i;
		p_next[STATUS_R] = 1'b1;
	end

	always_ff @(posedge sys_i, negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc <= 8'h00;
			x <= 8'h00;
			y <= 8'h00;
			sp <= 8'h00;
			ir <= 8'h00;
			p <= 8'h00 | (8'b1 << STATUS_R);
			pc <= RESET_VECTOR;
		end else begin
			if (dst_i == dst_acc)
				acc <= alu_res;
			if (dst_i == dst_x)
				x <= alu_res;
			if (dst_i == dst_y)
				y <= alu_res;
			if (dst_i == dst_sp)
				sp <= alu_res;
			if (ins_we_i)
				ir <= data_i;
			// High byte straight off the bus, low byte from the latch
			if (pc_load_i)
				pc <= {data_i, dll};
			else if (pc_inc_i)
				pc <= pc + 16'd1;
			p <= p_next;
		end
	end

	always_ff @(posedge sys_i) begin
		if (dst_i == dst_dll)
			dll <= alu_res;
		if (dst_i == dst_dlh)
			dlh <= alu_res;
	end

	assign addr_o = pc_addr_oe_i ? pc : {dlh, dll};
	assign data_o = alu_res;
	// Writes only go to the latched address
	assign we_o = bus_we_i & dl_addr_oe_i;
	assign ir_o = ir;

endmodule

// ==== hdl/cpu_top.sv ====
module cpu_top #(
	parameter logic [15:0] RESET_VECTOR = 16'hfffc
) (
	input  logic        sys_i,
	input  logic        arst_n_i,
	input  logic [7:0]  data_i,
	output logic [15:0] addr_o,
	output logic [7:0]  data_o,
	output logic        we_o
);
	import cpu_isa_pkg::*;
	import cpu_dp_pkg::*;

	logic [7:0] ir;
	opcode_t    op;
	addr_mode_t mode;
	logic       bus_we;
	logic       pc_addr_oe;
	logic       dl_addr_oe;
	logic       pc_inc;
	logic       pc_load;
	logic       ins_we;
	alu_func_t  alu_func;
	a_sel_t     a_sel;
	b_sel_t     b_sel;
	dst_t       dst;
	logic [7:0] p_mask;
	logic [7:0] p_set;
	logic [7:0] p_clr;

	opcode_decoder opcode_decoder_i (
		.ir_i   (ir),
		.op_o   (op),
		.mode_o (mode)
	);

	sequencer sequencer_i (
		.sys_i        (sys_i),
		.arst_n_i     (arst_n_i),
		.op_i         (op),
		.mode_i       (mode),
		.bus_we_o     (bus_we),
		.pc_addr_oe_o (pc_addr_oe),
		.dl_addr_oe_o (dl_addr_oe),
		.pc_inc_o     (pc_inc),
		.pc_load_o    (pc_load),
		.ins_we_o     (ins_we),
		.alu_func_o   (alu_func),
		.a_sel_o      (a_sel),
		.b_sel_o      (b_sel),
		.dst_o        (dst),
		.p_mask_o     (p_mask),
		.p_set_o      (p_set),
		.p_clr_o      (p_clr)
	);

	datapath #(
		.RESET_VECTOR (RESET_VECTOR)
	) datapath_i (
		.sys_i        (sys_i),
		.arst_n_i     (arst_n_i),
		.bus_we_i     (bus_we),
		.pc_addr_oe_i (pc_addr_oe),
		.dl_addr_oe_i (dl_addr_oe),
		.pc_inc_i     (pc_inc),
		.pc_load_i    (pc_load),
		.ins_we_i     (ins_we),
		.alu_func_i   (alu_func),
		.a_sel_i      (a_sel),
		.b_sel_i      (b_sel),
		.dst_i        (dst),
		.p_mask_i     (p_mask),
		.p_set_i      (p_set),
		.p_clr_i      (p_clr),
		.data_i       (data_i),
		.addr_o       (addr_o),
		.data_o       (data_o),
		.we_o         (we_o),
		.ir_o         (ir)
	);

endmodule

// ==== verification/tb_cpu.sv ====
module tb_cpu;

	localparam logic [15:0] VECTOR_ADDR = 16'hfffc;
	localparam logic [15:0] JUMP_ADDR = 16'h0200;
	localparam logic [15:0] PROG_ADDR = 16'h0300;
	localparam logic [15:0] RESULT_BASE = 16'h4000;
	localparam logic [15:0] DATA_BASE = 16'h6000;
	localparam int N_CASES = 40;
	localparam int WRITE_TIMEOUT = 200;

	// Reference operation kinds
	localparam int K_ADC = 0;
	localparam int K_SBC = 1;
	localparam int K_AND = 2;
	localparam int K_ORA = 3;
	localparam int K_EOR = 4;
	localparam int K_ASL = 5;
	localparam int K_LSR = 6;
	localparam int K_ROL = 7;
	localparam int K_ROR = 8;

	logic        sys;
	logic        arst_n;
	logic [7:0]  rdata;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        we;

	logic [7:0]  mem [0:65535];
	integer      seed;
	int          errors;
	int          checked;
	logic [15:0] wr_ptr;
	logic [15:0] res_ptr;
	logic [15:0] data_ptr;
	logic [15:0] exp_addr [$];
	logic [7:0]  exp_data [$];

	// Register state the program should leave in the core
	logic [7:0] m_acc;
	logic [7:0] m_x;
	logic [7:0] m_y;
	logic [7:0] m_sp;

	always begin
		sys = 1'b0;
		#5;
		sys = 1'b1;
		#5;
	end

	assign rdata = mem[addr];

	cpu_top cpu_top_i (
		.sys_i    (sys),
		.arst_n_i (arst_n),
		.data_i   (rdata),
		.addr_o   (addr),
		.data_o   (wdata),
		.we_o     (we)
	);

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[15:0]) % n;
	endfunction

	// Expected {carry, result} of one accumulator operation
	function automatic logic [8:0] expect_alu(
		input int         kind,
		input logic [7:0] a,
		input logic [7:0] b,
		input logic       c
	);
		int         s;
		logic [7:0] r;
		logic       co;
		r = a;
		co = c;
		case (kind)
		K_ADC: begin
			s = int'(a) + int'(b) + int'(c);
			r = s[7:0];
			co = s[8];
		end
		K_SBC: begin
			// Inverse of b is 255 - b
			s = int'(a) + 255 - int'(b) + int'(c);
			r = s[7:0];
			co = s[8];
		end
		K_AND: r = a & b;
		K_ORA: r = a | b;
		K_EOR: r = a ^ b;
		K_ASL: begin
			r = {a[6:0], 1'b0};
			co = a[7];
		end
		K_LSR: begin
			r = {1'b0, a[7:1]};
			co = a[0];
		end
		K_ROL: begin
			r = {a[6:0], c};
			co = a[7];
		end
		K_ROR: begin
			r = {c, a[7:1]};
			co = a[0];
		end
		default: ;
		endcase
		return {co, r};
	endfunction

	function automatic logic [7:0] alu_opcode(input int kind);
		case (kind)
		K_ADC:   return 8'h69;
		K_SBC:   return 8'he9;
		K_AND:   return 8'h29;
		K_ORA:   return 8'h09;
		K_EOR:   return 8'h49;
		K_ASL:   return 8'h0a;
		K_LSR:   return 8'h4a;
		K_ROL:   return 8'h2a;
		K_ROR:   return 8'h6a;
		default: return 8'hea;
		endcase
	endfunction

	// INX DEX INY DEY TAX TXA TAY TYA TXS TSX
	function automatic logic [7:0] index_opcode(input int pick);
		case (pick)
		0:       return 8'he8;
		1:       return 8'hca;
		2:       return 8'hc8;
		3:       return 8'h88;
		4:       return 8'haa;
		5:       return 8'h8a;
		6:       return 8'ha8;
		7:       return 8'h98;
		8:       return 8'h9a;
		default: return 8'hba;
		endcase
	endfunction

	task automatic fill_memory();
		logic [15:0] a;
		for (int i = 0; i < 65536; i++) begin
			a = 16'(i);
			mem[a] <= a[15:8] ^ a[7:0] ^ 8'ha5;
		end
	endtask

	task automatic put_byte(input logic [7:0] b);
		mem[wr_ptr] <= b;
		wr_ptr = wr_ptr + 16'd1;
	endtask

	task automatic put_abs(input logic [7:0] op, input logic [15:0] target);
		put_byte(op);
		put_byte(target[7:0]);
		put_byte(target[15:8]);
	endtask

	task automatic store_result(input logic [7:0] op, input logic [7:0] value);
		put_abs(op, res_ptr);
		exp_addr.push_back(res_ptr);
		exp_data.push_back(value);
		res_ptr = res_ptr + 16'd1;
	endtask

	// Flag ops that must not disturb any stored value
	task automatic put_flag_noise();
		int pick;
		pick = rand_below(10);
		case (pick)
		0: put_byte(8'hb8);
		1: put_byte(8'hf8);
		2: put_byte(8'hd8);
		3: put_byte(8'h78);
		4: put_byte(8'h58);
		default: ;
		endcase
	endtask

	task automatic build_alu_case();
		logic [7:0] a;
		logic [7:0] b;
		logic       c;
		int         kind;
		logic [8:0] res;
		a = rand_byte();
		b = rand_byte();
		c = (rand_below(2) == 1);
		kind = rand_below(5);
		put_byte(8'ha9);
		put_byte(a);
		put_byte(c ? 8'h38 : 8'h18);
		put_byte(alu_opcode(kind));
		put_byte(b);
		res = expect_alu(kind, a, b, c);
		m_acc = res[7:0];
		store_result(8'h8d, m_acc);
	endtask

	// ADC #0 folds the shifted-out carry into the stored byte
	task automatic build_shift_case();
		logic [7:0] a;
		logic       c;
		int         kind;
		logic [8:0] res;
		a = rand_byte();
		c = (rand_below(2) == 1);
		kind = K_ASL + rand_below(4);
		put_byte(8'ha9);
		put_byte(a);
		put_byte(c ? 8'h38 : 8'h18);
		put_byte(alu_opcode(kind));
		put_byte(8'h69);
		put_byte(8'h00);
		res = expect_alu(kind, a, 8'h00, c);
		res = expect_alu(K_ADC, res[7:0], 8'h00, res[8]);
		m_acc = res[7:0];
		store_result(8'h8d, m_acc);
	endtask

	task automatic build_index_case();
		int steps;
		int pick;
		m_x = rand_byte();
		m_y = rand_byte();
		put_byte(8'ha2);
		put_byte(m_x);
		put_byte(8'ha0);
		put_byte(m_y);
		steps = 3 + rand_below(6);
		for (int n = 0; n < steps; n++) begin
			pick = rand_below(10);
			put_byte(index_opcode(pick));
			case (pick)
			0: m_x = m_x + 8'd1;
			1: m_x = m_x - 8'd1;
			2: m_y = m_y + 8'd1;
			3: m_y = m_y - 8'd1;
			4: m_x = m_acc;
			5: m_acc = m_x;
			6: m_y = m_acc;
			7: m_acc = m_y;
			8: m_sp = m_x;
			default: m_x = m_sp;
			endcase
		end
		store_result(8'h8e, m_x);
		store_result(8'h8c, m_y);
	endtask

	task automatic build_load_case();
		logic [15:0] src;
		src = data_ptr;
		data_ptr = data_ptr + 16'd3;
		m_acc = rand_byte();
		m_x = rand_byte();
		m_y = rand_byte();
		mem[src] <= m_acc;
		mem[src + 16'd1] <= m_x;
		mem[src + 16'd2] <= m_y;
		put_abs(8'had, src);
		put_abs(8'hae, src + 16'd1);
		put_abs(8'hac, src + 16'd2);
		store_result(8'h8d, m_acc);
		store_result(8'h8e, m_x);
		store_result(8'h8c, m_y);
	endtask

	task automatic build_program();
		int          kind;
		logic [15:0] here;
		mem[VECTOR_ADDR] <= JUMP_ADDR[7:0];
		mem[VECTOR_ADDR + 16'd1] <= JUMP_ADDR[15:8];
		// Vector lands on a JMP into the program
		wr_ptr = JUMP_ADDR;
		put_abs(8'h4c, PROG_ADDR);
		wr_ptr = PROG_ADDR;
		for (int n = 0; n < N_CASES; n++) begin
			kind = rand_below(4);
			case (kind)
			0: build_alu_case();
			1: build_shift_case();
			2: build_index_case();
			default: build_load_case();
			endcase
			put_flag_noise();
		end
		here = wr_ptr;
		put_abs(8'h4c, here);
	endtask

	task automatic check_value(
		input string       what,
		input logic [15:0] got,
		input logic [15:0] expected
	);
		if (got !== expected) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic wait_for_write(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WRITE_TIMEOUT) begin
			@(negedge sys);
			if (we === 1'b1)
				seen = 1'b1;
			cycles++;
		end
	endtask

	initial begin
		logic        seen;
		logic        timed_out;
		logic [15:0] got_addr;
		logic [7:0]  got_data;
		logic [15:0] want_addr;
		logic [7:0]  want_data;
		arst_n = 1'b0;
		seed = 9;
		errors = 0;
		checked = 0;
		timed_out = 1'b0;
		res_ptr = RESULT_BASE;
		data_ptr = DATA_BASE;
		m_acc = 8'h00;
		m_x = 8'h00;
		m_y = 8'h00;
		m_sp = 8'h00;
		fill_memory();
		build_program();

		repeat (3) @(posedge sys);
		#1 arst_n = 1'b1;

		while (exp_addr.size() > 0 && !timed_out) begin
			wait_for_write(seen);
			if (!seen) begin
				$display("Timeout: the core stopped writing, %0d stores never came",
					exp_addr.size());
				errors++;
				timed_out = 1'b1;
			end else begin
				got_addr = addr;
				got_data = wdata;
				// Memory takes the byte at the edge that ends the cycle
				@(posedge sys);
				mem[got_addr] <= got_data;
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				check_value("store address", got_addr, want_addr);
				check_value("store data", {8'h00, got_data}, {8'h00, want_data});
				checked++;
			end
		end

		// Core parks on its final JMP
		if (!timed_out) begin
			for (int n = 0; n < 40; n++) begin
				@(negedge sys);
				if (we === 1'b1) begin
					$display("Unexpected write to %h after the last store", addr);
					errors++;
				end
			end
		end

		$display("Stores checked: %0d, errors: %0d", checked, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/cpu_isa_pkg.sv
hdl/cpu_dp_pkg.sv
hdl/opcode_decoder.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/datapath.sv
hdl/cpu_top.sv
verification/tb_cpu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_cpu -f tb.f
	./obj_dir/Vtb_cpu | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
